// ==== Makefile ====
SRCS = sram_pkg.sv sram_lane_bank.sv spsram_4096x32.sv sram_rr_arbiter.sv \
       blk_copy_engine.sv sram_subsys_top.sv tb_sram_subsys.sv tb_sram_tasks.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_sram_subsys: flist.f $(SRCS)
	verilator --binary --timing --top-module tb_sram_subsys -f flist.f

# Pass needs the pass line and no fail line in the log
run: obj_dir/Vtb_sram_subsys
	./obj_dir/Vtb_sram_subsys | tee sim.log
	grep -q "all tests passed" sim.log
	! grep -q "tests failed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== blk_copy_engine.sv ====
// Block copy engine
// Reads a run of words from a source address and writes them
// to a destination, one read grant then one write grant per word
// Busy level while copying, done pulse after the last write

module blk_copy_engine #(
  parameter int COPY_MAX_LEN_LOG2 = 8
) (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                copy_start,
  input  sram_pkg::addr_t     copy_src,
  input  sram_pkg::addr_t     copy_dst,
  input  sram_pkg::copy_len_t copy_len,
  input  logic                ce_gnt,
  input  logic                ce_rvalid,
  input  sram_pkg::word_t     rdata,
  output sram_pkg::mem_req_t  ce_req,
  output logic                copy_busy,
  output logic                copy_done
);

  import sram_pkg::*;

  // Words left, wide enough for the largest run
  typedef logic [COPY_MAX_LEN_LOG2:0] cnt_t;

  copy_state_t state;
  cnt_t        remain;
  // Read granted, waiting for its data
  logic        rd_wait;
  addr_t       src_ptr;
  addr_t       dst_ptr;
  // Word in flight between read and write
  word_t       buf_q;

  // Control FSM
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state   <= IDLE;
      remain  <= '0;
      rd_wait <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // Start is only taken here, ignored while busy
          if (copy_start) begin
            remain <= cnt_t'(copy_len);
            state  <= RD;
          end
        end
        RD: begin
          if (ce_gnt) begin
            rd_wait <= 1'b1;
          end
          // Data arrives the cycle after the read grant
          if (ce_rvalid) begin
            rd_wait <= 1'b0;
            state   <= WR;
          end
        end
        WR: begin
          if (ce_gnt) begin
            remain <= remain - cnt_t'(1);
            state  <= (remain == cnt_t'(1)) ? FINISH : RD;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Pointers and data buffer
  always_ff @(posedge CLK) begin
    if (state == IDLE && copy_start) begin
      src_ptr <= copy_src;
      dst_ptr <= copy_dst;
    end else if (state == WR && ce_gnt) begin
      // 12-bit pointers wrap around the top of memory
      src_ptr <= src_ptr + addr_t'(1);
      dst_ptr <= dst_ptr + addr_t'(1);
    end
    if (state == RD && ce_rvalid) begin
      buf_q <= rdata;
    end
  end

  // Request toward the arbiter
  always_comb begin
    ce_req.req   = (state == RD && !rd_wait) || (state == WR);
    ce_req.write = (state == WR);
    ce_req.addr  = (state == WR) ? dst_ptr : src_ptr;
    ce_req.wdata = buf_q;
    ce_req.be    = '1;
  end

  assign copy_busy = (state == RD) || (state == WR);
  // FINISH lasts one cycle, right after the last write grant
  assign copy_done = (state == FINISH);

endmodule

// ==== flist.f ====
+incdir+.
sram_pkg.sv
sram_lane_bank.sv
spsram_4096x32.sv
sram_rr_arbiter.sv
blk_copy_engine.sv
sram_subsys_top.sv
tb_sram_subsys.sv

// ==== spsram_4096x32.sv ====
// 4096x32 single-port memory wrapper
// Active-low chip enable, global and per-bit write enables
// Four byte-lane banks, address held while disabled

module spsram_4096x32 (
  input  logic                         CLK,
  input  sram_pkg::addr_t              a,
  input  logic                         cen,
  input  logic                         gwen,
  input  logic [sram_pkg::MEM_DW-1:0]  wen,
  input  sram_pkg::word_t              d,
  output sram_pkg::word_t              q
);

  import sram_pkg::*;

  // Bits per lane bank
  localparam int LANE_W = MEM_DW / MEM_LANES;

  // Last address seen with the chip enabled
  addr_t addr_hold;
  // Address actually presented to the banks
  addr_t bank_addr;

  always_ff @(posedge CLK) begin
    if (!cen) begin
      addr_hold <= a;
    end
  end

  // Disabled chip keeps re-reading the held word
  // so q stays put between accesses
  assign bank_addr = cen ? addr_hold : a;

  for (genvar i = 0; i < MEM_LANES; i++) begin : g_lane
    logic lane_we;

    // Lane write needs chip enable, global write and
    // the top wen bit of this lane, all low
    assign lane_we = !cen && !gwen && !wen[i*LANE_W + LANE_W - 1];

    sram_lane_bank #(
      .LANE_WIDTH (LANE_W),
      .ADDR_WIDTH (MEM_AW)
    ) u_bank (
      .CLK  (CLK),
      .addr (bank_addr),
      .din  (d[i*LANE_W +: LANE_W]),
      .we   (lane_we),
      .dout (q[i*LANE_W +: LANE_W])
    );
  end

endmodule

// ==== sram_lane_bank.sv ====
// Single byte-lane RAM bank
// Synchronous write, registered read-first output

module sram_lane_bank #(
  parameter int LANE_WIDTH = 8,
  parameter int ADDR_WIDTH = 12
) (
  input  logic                  CLK,
  input  logic [ADDR_WIDTH-1:0] addr,
  input  logic [LANE_WIDTH-1:0] din,
  input  logic                  we,
  output logic [LANE_WIDTH-1:0] dout
);

  // Lane storage
  logic [LANE_WIDTH-1:0] mem [2**ADDR_WIDTH];

  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= din;
    end
    // Read every cycle, old contents on a same-address write
    dout <= mem[addr];
  end

endmodule

// ==== sram_pkg.sv ====
// Shared memory subsystem definitions
// Geometry constants, vector typedefs, master request struct
// and the copy engine state encoding

package sram_pkg;

  // Memory geometry, 4096 x 32 in byte lanes
  localparam int MEM_AW    = 12;
  localparam int MEM_DW    = 32;
  localparam int MEM_LANES = 4;

  // Word address into the data memory
  typedef logic [MEM_AW-1:0] addr_t;

  // Full data word
  typedef logic [MEM_DW-1:0] word_t;

  // Byte enables, one per lane, active high
  typedef logic [MEM_LANES-1:0] be_t;

  // Copy length in words
  typedef logic [7:0] copy_len_t;

  // One master's request toward the arbiter
  // Held steady until the matching grant pulse
  typedef struct packed {
    logic  req;
    logic  write;
    addr_t addr;
    word_t wdata;
    be_t   be;
  } mem_req_t;

  // Block copy FSM
  typedef enum logic [1:0] {
    IDLE,
    RD,
    WR,
    FINISH
  } copy_state_t;

endpackage

// ==== sram_rr_arbiter.sv ====
// Two-master round-robin arbiter for the shared memory
// Host port against copy engine, one grant per cycle
// Drives the wrapper's active-low controls
// Returns read-data strobes one cycle after the grant

module sram_rr_arbiter (
  input  logic                        CLK,
  input  logic                        rst_n,
  input  sram_pkg::mem_req_t          host_req,
  input  sram_pkg::mem_req_t          ce_req,
  output logic                        host_gnt,
  output logic                        ce_gnt,
  output logic                        host_rvalid,
  output logic                        ce_rvalid,
  output sram_pkg::addr_t             a,
  output sram_pkg::word_t             d,
  output logic                        cen,
  output logic                        gwen,
  output logic [sram_pkg::MEM_DW-1:0] wen
);

  import sram_pkg::*;

  localparam int LANE_W = MEM_DW / MEM_LANES;

  // High when the copy engine had the last grant
  logic     last_ce;
  // Copy engine wins this cycle
  logic     pick_ce;
  // Any access this cycle
  logic     any_gnt;
  // Winning request
  mem_req_t sel;

  // Copy engine wins if alone, or on a tie when the host went last
  assign pick_ce  = ce_req.req && (!host_req.req || !last_ce);
  assign ce_gnt   = pick_ce;
  assign host_gnt = host_req.req && !pick_ce;
  assign any_gnt  = host_gnt || ce_gnt;

  assign sel = pick_ce ? ce_req : host_req;

  // Memory side, all controls active low
  always_comb begin
    a    = sel.addr;
    d    = sel.wdata;
    cen  = !any_gnt;
    gwen = !(any_gnt && sel.write);
    // One be bit fans out to a whole lane of wen bits
    for (int i = 0; i < MEM_LANES; i++) begin
      wen[i*LANE_W +: LANE_W] = {LANE_W{!sel.be[i]}};
    end
  end

  // Round-robin pointer, moves on every grant
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      last_ce <= 1'b0;
    end else if (any_gnt) begin
      last_ce <= ce_gnt;
    end
  end

  // Read owner flags, q is valid one cycle after a read grant
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      host_rvalid <= 1'b0;
      ce_rvalid   <= 1'b0;
    end else begin
      host_rvalid <= host_gnt && !host_req.write;
      ce_rvalid   <= ce_gnt && !ce_req.write;
    end
  end

endmodule

// ==== sram_subsys_top.sv ====
// Shared data memory subsystem top
// Host port and block copy engine behind a round-robin arbiter
// in front of the 4096x32 memory wrapper

module sram_subsys_top #(
  parameter int COPY_MAX_LEN_LOG2 = 8
) (
  input  logic                CLK,
  input  logic                rst_n,
  input  sram_pkg::mem_req_t  host_req,
  output logic                host_gnt,
  output logic                host_rvalid,
  output sram_pkg::word_t     host_rdata,
  input  logic                copy_start,
  input  sram_pkg::addr_t     copy_src,
  input  sram_pkg::addr_t     copy_dst,
  input  sram_pkg::copy_len_t copy_len,
  output logic                copy_busy,
  output logic                copy_done
);

  import sram_pkg::*;

  // Copy engine side of the arbiter
  mem_req_t            ce_req;
  logic                ce_gnt;
  logic                ce_rvalid;
  // Memory controls, active low
  addr_t               mem_a;
  word_t               mem_d;
  logic                mem_cen;
  logic                mem_gwen;
  logic [MEM_DW-1:0]   mem_wen;
  // Shared read bus
  word_t               mem_q;

  assign host_rdata = mem_q;

  sram_rr_arbiter u_arb (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .host_req    (host_req),
    .ce_req      (ce_req),
    .host_gnt    (host_gnt),
    .ce_gnt      (ce_gnt),
    .host_rvalid (host_rvalid),
    .ce_rvalid   (ce_rvalid),
    .a           (mem_a),
    .d           (mem_d),
    .cen         (mem_cen),
    .gwen        (mem_gwen),
    .wen         (mem_wen)
  );

  blk_copy_engine #(
    .COPY_MAX_LEN_LOG2 (COPY_MAX_LEN_LOG2)
  ) u_copy (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .copy_start (copy_start),
    .copy_src   (copy_src),
    .copy_dst   (copy_dst),
    .copy_len   (copy_len),
    .ce_gnt     (ce_gnt),
    .ce_rvalid  (ce_rvalid),
    .rdata      (mem_q),
    .ce_req     (ce_req),
    .copy_busy  (copy_busy),
    .copy_done  (copy_done)
  );

  spsram_4096x32 u_mem (
    .CLK  (CLK),
    .a    (mem_a),
    .cen  (mem_cen),
    .gwen (mem_gwen),
    .wen  (mem_wen),
    .d    (mem_d),
    .q    (mem_q)
  );

endmodule

// ==== tb_sram_tasks.svh ====
// Testbench helpers for the shared memory subsystem
// Galois LFSR, reference memory model, host port access
// and block copy start and check tasks

`ifndef TB_SRAM_TASKS_SVH
`define TB_SRAM_TASKS_SVH

  // Reference copy of the whole memory
  word_t model_mem [1 << MEM_AW];

  // 32-bit Galois LFSR, right shifting
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // n fresh bits, one LFSR step per bit
  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // Byte-lane write into the model
  function automatic void model_write(input addr_t addr, input word_t data, input be_t be);
    for (int i = 0; i < MEM_LANES; i++) begin
      if (be[i]) begin
        model_mem[addr][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endfunction

  // One host access, held until granted
  // Returns q from the cycle after the grant
  task automatic host_access(input logic wr, input addr_t addr, input word_t wdata,
                             input be_t be, output word_t rdata);
    @(posedge CLK);
    host_req.req   <= 1'b1;
    host_req.write <= wr;
    host_req.addr  <= addr;
    host_req.wdata <= wdata;
    host_req.be    <= be;
    // Grant is combinational, look mid-cycle
    do begin
      @(negedge CLK);
    end while (!host_gnt);
    @(posedge CLK);
    host_req.req <= 1'b0;
    @(negedge CLK);
    rdata = host_rdata;
  endtask

  task automatic write_word(input addr_t addr, input word_t data, input be_t be);
    word_t dummy;
    host_access(1'b1, addr, data, be, dummy);
    model_write(addr, data, be);
  endtask

  task automatic read_check(input addr_t addr);
    word_t got;
    host_access(1'b0, addr, '0, '0, got);
    if (got !== model_mem[addr]) begin
      $display("FAILED host_rdata at %h: got %h expected %h", addr, got, model_mem[addr]);
      err_count++;
    end
  endtask

  task automatic expect_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      err_count++;
    end
  endtask

  task automatic fill_random(input addr_t base, input int len);
    for (int i = 0; i < len; i++) begin
      write_word(base + addr_t'(i), rand_bits(32), '1);
    end
  endtask

  task automatic check_region(input addr_t base, input int len);
    for (int i = 0; i < len; i++) begin
      read_check(base + addr_t'(i));
    end
  endtask

  // Start pulse for one cycle, busy must follow
  task automatic start_copy(input addr_t src, input addr_t dst, input int len);
    @(posedge CLK);
    copy_start <= 1'b1;
    copy_src   <= src;
    copy_dst   <= dst;
    copy_len   <= copy_len_t'(len);
    @(posedge CLK);
    copy_start <= 1'b0;
    @(negedge CLK);
    expect_bit("copy_busy", copy_busy, 1'b1);
  endtask

  // Wait for done, then apply the copy rule to the model
  task automatic finish_copy(input int done_before, input addr_t src, input addr_t dst,
                             input int len);
    while (done_count == done_before) begin
      @(negedge CLK);
    end
    // Idle a little to catch a second done pulse
    repeat (4) @(negedge CLK);
    if (done_count != done_before + 1) begin
      $display("FAILED copy_done pulses: got %h expected %h", done_count - done_before, 1);
      err_count++;
    end
    expect_bit("copy_busy", copy_busy, 1'b0);
    for (int i = 0; i < len; i++) begin
      model_mem[dst + addr_t'(i)] = model_mem[src + addr_t'(i)];
    end
  endtask

`endif

// ==== tb_sram_subsys.sv ====
// Testbench for the shared memory subsystem
// Clock, reset, DUT, protocol monitor and timeout
// Random host and copy traffic checked against a memory model

module tb_sram_subsys;

  import sram_pkg::*;

  localparam int          COPY_MAX_LEN_LOG2 = 8;
  localparam logic [31:0] LFSR_SEED         = 32'd95276;
  localparam int          N_WORD_OPS        = 40;
  localparam int          N_BE_OPS          = 40;
  // Longest random copy in words
  localparam int          N_COPY_MAX        = 32;
  localparam int          N_HOST_BG         = 24;
  // Host accesses over the whole run
  localparam int          HOST_OPS = 2*N_WORD_OPS + 3*N_BE_OPS + 1
                                     + 4*N_COPY_MAX + 2*N_HOST_BG;
  // About 5 cycles per host access, 6 per copied word, doubled
  localparam int          TIMEOUT_CYCLES = 2 * (5*HOST_OPS + 12*N_COPY_MAX + 64);

  logic        CLK;
  logic        rst_n;
  mem_req_t    host_req;
  logic        host_gnt;
  logic        host_rvalid;
  word_t       host_rdata;
  logic        copy_start;
  addr_t       copy_src;
  addr_t       copy_dst;
  copy_len_t   copy_len;
  logic        copy_busy;
  logic        copy_done;

  logic [31:0] lfsr_state;
  int          cycle_count;
  int          err_count;
  int          err_at_start;
  int          done_count;
  int          tests_run;
  int          tests_passed;
  // Read grant seen last cycle, so rvalid is due now
  logic        exp_rvalid;
  addr_t       wr_addr [N_WORD_OPS];

  `include "tb_sram_tasks.svh"

  sram_subsys_top #(
    .COPY_MAX_LEN_LOG2 (COPY_MAX_LEN_LOG2)
  ) u_dut (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .host_req    (host_req),
    .host_gnt    (host_gnt),
    .host_rvalid (host_rvalid),
    .host_rdata  (host_rdata),
    .copy_start  (copy_start),
    .copy_src    (copy_src),
    .copy_dst    (copy_dst),
    .copy_len    (copy_len),
    .copy_busy   (copy_busy),
    .copy_done   (copy_done)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  // Run limit
  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("run stopped at cycle %0d, a request or copy never completed", cycle_count);
      $display("tests failed");
      $finish;
    end
  end

  // Mid-cycle monitor: rvalid timing and done pulses
  always @(negedge CLK) begin
    if (rst_n) begin
      expect_bit("host_rvalid", host_rvalid, exp_rvalid);
      if (copy_done) begin
        done_count++;
        // Busy drops together with done
        expect_bit("copy_busy", copy_busy, 1'b0);
      end
    end
    exp_rvalid = rst_n && host_gnt && !host_req.write;
  end

  task automatic end_test(input string name);
    tests_run++;
    if (err_count == err_at_start) begin
      tests_passed++;
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      $display("test %0d %s: fail with %0d errors", tests_run, name, err_count - err_at_start);
    end
    err_at_start = err_count;
  endtask

  initial begin
    addr_t a;
    addr_t src;
    addr_t dst;
    int    len;
    int    done_before;

    lfsr_state   = LFSR_SEED;
    cycle_count  = 0;
    err_count    = 0;
    err_at_start = 0;
    done_count   = 0;
    tests_run    = 0;
    tests_passed = 0;
    exp_rvalid   = 1'b0;
    rst_n        = 1'b0;
    host_req     = '0;
    copy_start   = 1'b0;
    copy_src     = '0;
    copy_dst     = '0;
    copy_len     = '0;
    repeat (4) @(posedge CLK);
    rst_n <= 1'b1;

    // Outputs quiet after reset
    @(negedge CLK);
    expect_bit("host_gnt", host_gnt, 1'b0);
    expect_bit("host_rvalid", host_rvalid, 1'b0);
    expect_bit("copy_busy", copy_busy, 1'b0);
    expect_bit("copy_done", copy_done, 1'b0);
    end_test("reset state");

    // Region 0x000 to 0x0ff for plain host traffic
    for (int i = 0; i < N_WORD_OPS; i++) begin
      wr_addr[i] = addr_t'(rand_bits(8));
      write_word(wr_addr[i], rand_bits(32), '1);
    end
    for (int i = 0; i < N_WORD_OPS; i++) begin
      read_check(wr_addr[i]);
    end
    end_test("host word write and read");

    for (int i = 0; i < N_BE_OPS; i++) begin
      a = addr_t'(rand_bits(8));
      write_word(a, rand_bits(32), '1);
      write_word(a, rand_bits(32), be_t'(rand_bits(4)));
      read_check(a);
    end
    end_test("byte enable writes");

    // Idle chip keeps the last read word on q
    // even with the idle address and data buses moving
    a = wr_addr[0];
    read_check(a);
    for (int i = 0; i < 6; i++) begin
      @(posedge CLK);
      host_req.addr  <= a ^ addr_t'(i + 1);
      host_req.wdata <= rand_bits(32);
      @(negedge CLK);
      if (host_rdata !== model_mem[a]) begin
        $display("FAILED host_rdata idle at %h: got %h expected %h", a, host_rdata,
                 model_mem[a]);
        err_count++;
      end
    end
    end_test("read data hold");

    // Copy alone, source 0x400, destination 0x800
    src = 12'h400;
    dst = 12'h800;
    len = int'(rand_bits(5)) + 1;
    fill_random(src, len);
    done_before = done_count;
    start_copy(src, dst, len);
    finish_copy(done_before, src, dst, len);
    check_region(dst, len);
    end_test("block copy");

    // Copy with host traffic in 0xc00 to 0xcff
    src = 12'h500;
    dst = 12'h900;
    len = int'(rand_bits(5)) + 1;
    fill_random(src, len);
    done_before = done_count;
    start_copy(src, dst, len);
    for (int i = 0; i < N_HOST_BG; i++) begin
      a = 12'hC00 + addr_t'(rand_bits(8));
      write_word(a, rand_bits(32), '1);
      read_check(a);
    end
    finish_copy(done_before, src, dst, len);
    check_region(dst, len);
    end_test("copy with host traffic");

    $display("summary: %0d tests run, %0d passed, %0d errors", tests_run, tests_passed,
             err_count);
    if (err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
